//--- run_sim.sh
#!/bin/sh
# Build the x86 decode testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

verilator --binary --top-module x86_decode_tb -f x86_decode.f -o x86_decode_sim

./obj_dir/x86_decode_sim > sim.log 2>&1
cat sim.log

if grep -qx "Regression passed" sim.log; then
  exit 0
else
  exit 1
fi

//--- tests/tb_clock.sv
/*
  Testbench clock and reset. 4 ns period, reset high for two rising edges
  and released on the following falling edge.
*/
`default_nettype none
`timescale 1ns/10ps

module tb_clock (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

`default_nettype wire

//--- tests/x86_decode_tb.sv
/*
  Random instruction testbench for the decode stage. Inputs change on the
  falling edge; outputs are sampled on the falling edge as well.
  Every result is expected exactly two cycles after its strobe.
*/
`default_nettype none
`timescale 1ns/10ps
`include "x86_decode_config.svh"

module x86_decode_tb import x86_decode_pkg::*; ();

  typedef struct packed {
    logic [31:0] cyc;
    logic [3:0]  len;
    logic [31:0] eip_next;
    logic [7:0]  opcode;
    logic [7:0]  modrm;
    logic [31:0] disp;
    logic [31:0] imm;
    logic [15:0] ptr;
    logic        has_modrm;
    logic        repne;
    logic        op_size;
    logic        seg_over;
    logic [2:0]  seg;
    logic        esc;
    logic        hlt;
    logic        iret;
    logic        unsup;
  } expect_t;

  logic                       clk;
  logic                       rst;
  logic                       fetch_valid;
  logic [8*`WINDOW_BYTES-1:0] fetch_bytes;
  logic [`EIP_W-1:0]          fetch_eip;
  logic                       de_valid;
  logic [`LEN_W-1:0]          de_length;
  logic [`EIP_W-1:0]          de_eip_next;
  logic [7:0]                 de_opcode;
  logic [7:0]                 de_modrm;
  logic [31:0]                de_disp32;
  logic [31:0]                de_imm32;
  logic [15:0]                de_ptr_cs;
  logic                       de_repne;
  logic                       de_op_size_over;
  logic                       de_seg_over;
  seg_e                       de_seg;
  logic                       de_esc_0f;
  logic                       de_hlt;
  logic                       de_iret;
  logic                       de_unsupported;

  logic [7:0] win [`WINDOW_BYTES];
  expect_t    exp_q [$];
  int         cyc;
  int         checks;
  int         errors;
  int         tests;

  tb_clock clkgen (
    .clk (clk),
    .rst (rst)
  );

  x86_decode_top uut (
    .clk             (clk),
    .rst             (rst),
    .fetch_valid     (fetch_valid),
    .fetch_bytes     (fetch_bytes),
    .fetch_eip       (fetch_eip),
    .de_valid        (de_valid),
    .de_length       (de_length),
    .de_eip_next     (de_eip_next),
    .de_opcode       (de_opcode),
    .de_modrm        (de_modrm),
    .de_disp32       (de_disp32),
    .de_imm32        (de_imm32),
    .de_ptr_cs       (de_ptr_cs),
    .de_repne        (de_repne),
    .de_op_size_over (de_op_size_over),
    .de_seg_over     (de_seg_over),
    .de_seg          (de_seg),
    .de_esc_0f       (de_esc_0f),
    .de_hlt          (de_hlt),
    .de_iret         (de_iret),
    .de_unsupported  (de_unsupported)
  );

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] want);
    checks++;
    if (got !== want) begin
      $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, want);
      errors++;
    end
  endtask

  function automatic logic is_prefix(input logic [7:0] b);
    case (b)
      8'hF2, 8'h2E, 8'h36, 8'h3E, 8'h26, 8'h64, 8'h65, 8'h66, 8'h0F: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [7:0] prefix_byte(input int k);
    case (k)
      0: return 8'hF2;
      1: return 8'h2E;
      2: return 8'h36;
      3: return 8'h3E;
      4: return 8'h26;
      5: return 8'h64;
      6: return 8'h65;
      7: return 8'h66;
      default: return 8'h0F;
    endcase
  endfunction

  function automatic logic [7:0] table_opcode(input int k);
    case (k)
      0: return 8'h90;
      1: return 8'hC3;
      2: return 8'hF4;
      3: return 8'hCF;
      4: return 8'h01;
      5: return 8'h03;
      6: return 8'h89;
      7: return 8'h8B;
      8: return 8'h83;
      9: return 8'h81;
      10: return 8'hC7;
      11: return 8'h04;
      12: return 8'h6A;
      13: return 8'hB8 + 8'($urandom % 8);
      14: return 8'hE8;
      15: return 8'hE9;
      default: return 8'hEA;
    endcase
  endfunction

  function automatic op_class_e classify(input logic [7:0] op, input logic esc);
    if (esc) begin
      if (op == 8'h6F || op == 8'h7F) return OPC_MODRM;
      return OPC_UNSUPPORTED;
    end
    // MOV r32, imm32 block
    if (op[7:3] == 5'b10111) return OPC_IMMZ;
    case (op)
      8'h90, 8'hC3, 8'hF4, 8'hCF: return OPC_NONE;
      8'h01, 8'h03, 8'h89, 8'h8B: return OPC_MODRM;
      8'h83: return OPC_MODRM_IMM8;
      8'h81, 8'hC7: return OPC_MODRM_IMMZ;
      8'h04, 8'h6A: return OPC_IMM8;
      8'hE8, 8'hE9: return OPC_IMMZ;
      8'hEA: return OPC_FAR_PTR;
      default: return OPC_UNSUPPORTED;
    endcase
  endfunction

  function automatic logic [7:0] filler_byte();
    logic [7:0] b;
    do b = 8'($urandom); while (b == 8'h0F);
    return b;
  endfunction

  function automatic logic [7:0] unsupported_byte(input logic esc);
    logic [7:0] b;
    do b = 8'($urandom); while (is_prefix(b) || classify(b, esc) != OPC_UNSUPPORTED);
    return b;
  endfunction

  // Little-endian field of n bytes starting at window position pos
  function automatic logic [31:0] le_field(input int pos, input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[8*i +: 8] = win[pos + i];
    end
    return v;
  endfunction

  function automatic expect_t predict(input logic [31:0] eip);
    expect_t    e;
    op_class_e  cls;
    int         cnt;
    int         imm_n;
    int         sel_n;
    int         disp_n;
    int         sib;
    int         tail;
    int         len;
    logic [7:0] m;
    logic [7:0] s;
    logic [5:0] seg_hit;
    e = '0;
    seg_hit = '0;
    cnt = 0;
    while (cnt < `MAX_PREFIX && is_prefix(win[cnt])) cnt++;
    for (int i = 0; i < cnt; i++) begin
      case (win[i])
        8'hF2: e.repne = 1'b1;
        8'h66: e.op_size = 1'b1;
        8'h0F: e.esc = 1'b1;
        8'h26: seg_hit[0] = 1'b1;
        8'h2E: seg_hit[1] = 1'b1;
        8'h36: seg_hit[2] = 1'b1;
        8'h3E: seg_hit[3] = 1'b1;
        8'h64: seg_hit[4] = 1'b1;
        default: seg_hit[5] = 1'b1;
      endcase
    end
    e.seg_over = |seg_hit;
    // First present override in ES, CS, SS, DS, FS, GS order
    if (seg_hit[0]) e.seg = SEG_ES;
    else if (seg_hit[1]) e.seg = SEG_CS;
    else if (seg_hit[2]) e.seg = SEG_SS;
    else if (seg_hit[3]) e.seg = SEG_DS;
    else if (seg_hit[4]) e.seg = SEG_FS;
    else e.seg = SEG_GS;
    e.opcode = win[cnt];
    e.modrm = win[cnt + 1];
    m = win[cnt + 1];
    s = win[cnt + 2];
    cls = classify(e.opcode, e.esc);
    imm_n = 0;
    sel_n = 0;
    case (cls)
      OPC_MODRM_IMM8, OPC_IMM8: imm_n = 1;
      OPC_MODRM_IMMZ, OPC_IMMZ: imm_n = e.op_size ? 2 : 4;
      OPC_FAR_PTR: begin
        imm_n = e.op_size ? 2 : 4;
        sel_n = 2;
      end
      default: ;
    endcase
    e.has_modrm = (cls == OPC_MODRM || cls == OPC_MODRM_IMM8 || cls == OPC_MODRM_IMMZ);
    tail = 0;
    sib = 0;
    disp_n = 0;
    if (e.has_modrm) begin
      if (m[7:6] == 2'b11) begin
        tail = 1;
      end else if (m[7:6] == 2'b00 && m[2:0] == 3'b101) begin
        disp_n = 4;
        tail = 5;
      end else begin
        sib = (m[2:0] == 3'b100) ? 1 : 0;
        if (m[7:6] == 2'b10 || (m[7:6] == 2'b00 && sib == 1 && s[2:0] == 3'b101)) begin
          disp_n = 4;
        end else if (m[7:6] == 2'b01) begin
          disp_n = 1;
        end
        tail = 1 + sib + disp_n;
      end
    end
    len = cnt + 1 + tail + imm_n + sel_n;
    e.len = 4'(len);
    e.eip_next = eip + 32'(len);
    e.disp = le_field(cnt + 2 + sib, disp_n);
    if (disp_n == 1) e.disp = {{24{e.disp[7]}}, e.disp[7:0]};
    e.imm = le_field(cnt + 1 + tail, imm_n);
    e.ptr = 16'(le_field(cnt + 1 + tail + imm_n, sel_n));
    e.hlt = (e.opcode == 8'hF4);
    e.iret = (e.opcode == 8'hCF);
    e.unsup = (cls == OPC_UNSUPPORTED);
    e.cyc = 32'(cyc);
    return e;
  endfunction

  // mode 0 random, 1 EIP near wraparound, 2 unsupported opcode
  task automatic load_instr(input int mode);
    int          npfx;
    logic        esc;
    logic [7:0]  op;
    logic [31:0] eip;
    esc = 1'b0;
    for (int i = 0; i < `WINDOW_BYTES; i++) begin
      win[i] = filler_byte();
    end
    npfx = int'($urandom % 5);
    for (int i = 0; i < npfx; i++) begin
      win[i] = prefix_byte(int'($urandom % 9));
      if (win[i] == 8'h0F) esc = 1'b1;
    end
    if (mode == 2 || $urandom % 8 == 0) begin
      op = unsupported_byte(esc);
    end else if (esc) begin
      op = ($urandom % 2 == 0) ? 8'h6F : 8'h7F;
    end else begin
      op = table_opcode(int'($urandom % 17));
    end
    win[npfx] = op;
    // Push some cases into SIB with base 101
    if ($urandom % 4 == 0) begin
      win[npfx + 1][2:0] = 3'b100;
      win[npfx + 2][2:0] = 3'b101;
    end
    eip = (mode == 1) ? 32'hFFFF_FFFF - ($urandom % 16) : $urandom;
    for (int i = 0; i < `WINDOW_BYTES; i++) begin
      fetch_bytes[8*i +: 8] = win[i];
    end
    fetch_eip = eip;
    exp_q.push_back(predict(eip));
  endtask

  task automatic compare_result();
    expect_t e;
    if (exp_q.size() == 0 || cyc - int'(exp_q[0].cyc) < 2) begin
      check_value("de_valid", 32'(de_valid), 32'd0);
    end else begin
      e = exp_q.pop_front();
      check_value("de_valid", 32'(de_valid), 32'd1);
      if (de_valid) begin
        check_value("de_length", 32'(de_length), 32'(e.len));
        check_value("de_eip_next", de_eip_next, e.eip_next);
        check_value("de_opcode", 32'(de_opcode), 32'(e.opcode));
        if (e.has_modrm) check_value("de_modrm", 32'(de_modrm), 32'(e.modrm));
        check_value("de_disp32", de_disp32, e.disp);
        check_value("de_imm32", de_imm32, e.imm);
        check_value("de_ptr_cs", 32'(de_ptr_cs), 32'(e.ptr));
        check_value("de_repne", 32'(de_repne), 32'(e.repne));
        check_value("de_op_size_over", 32'(de_op_size_over), 32'(e.op_size));
        check_value("de_seg_over", 32'(de_seg_over), 32'(e.seg_over));
        if (e.seg_over) check_value("de_seg", 32'(de_seg), 32'(e.seg));
        check_value("de_esc_0f", 32'(de_esc_0f), 32'(e.esc));
        check_value("de_hlt", 32'(de_hlt), 32'(e.hlt));
        check_value("de_iret", 32'(de_iret), 32'(e.iret));
        check_value("de_unsupported", 32'(de_unsupported), 32'(e.unsup));
      end
    end
  endtask

  task automatic step_cycle(input logic strobe, input int mode);
    @(negedge clk);
    cyc++;
    compare_result();
    if (strobe) begin
      load_instr(mode);
      fetch_valid = 1'b1;
    end else begin
      fetch_valid = 1'b0;
    end
  endtask

  task automatic wait_for_reset();
    int n;
    n = 0;
    while (rst !== 1'b0 && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (rst !== 1'b0) begin
      $display("Reset was never released");
      errors++;
    end
  endtask

  task automatic drain_results();
    int n;
    n = 0;
    while ((exp_q.size() != 0 || fetch_valid) && n < 16) begin
      step_cycle(1'b0, 0);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("Timed out waiting for %0d outstanding results", exp_q.size());
      errors++;
      exp_q.delete();
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests++;
    $display("Test %s done with %0d errors", name, errors - errors_before);
  endtask

  initial begin
    logic [31:0] seed_ret;
    int          e0;
    fetch_valid = 1'b0;
    fetch_bytes = '0;
    fetch_eip = '0;
    cyc = 0;
    checks = 0;
    errors = 0;
    tests = 0;
    seed_ret = $urandom(32'h6dbb);
    wait_for_reset();

    e0 = errors;
    for (int i = 0; i < 8; i++) step_cycle(1'b0, 0);
    report_test("reset_idle", e0);

    e0 = errors;
    for (int i = 0; i < 400; i++) step_cycle(($urandom % 4) != 0, 0);
    drain_results();
    report_test("random_mix", e0);

    e0 = errors;
    for (int i = 0; i < 64; i++) step_cycle(1'b1, 0);
    drain_results();
    report_test("back_to_back", e0);

    e0 = errors;
    for (int i = 0; i < 48; i++) step_cycle(1'b1, 1);
    drain_results();
    report_test("eip_wrap", e0);

    e0 = errors;
    for (int i = 0; i < 48; i++) step_cycle(($urandom % 2) != 0, 2);
    drain_results();
    report_test("unsupported", e0);

    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/decode_if.sv
/*
  Latched instruction passed from the field stage to the length decoder.
  No handshake; valid is a one-cycle strobe per instruction.
*/
`default_nettype none
`timescale 1ns/10ps
`include "x86_decode_config.svh"

interface decode_if import x86_decode_pkg::*; ();

  logic                       valid;
  logic [8*`WINDOW_BYTES-1:0] bytes;
  logic [`EIP_W-1:0]          eip;
  logic [7:0]                 opcode;
  logic [7:0]                 modrm;
  logic [7:0]                 sib;
  prefix_info_t               pinfo;

  modport stage (output valid, bytes, eip, opcode, modrm, sib, pinfo);

  modport decoder (input valid, bytes, eip, opcode, modrm, sib, pinfo);

endinterface

`default_nettype wire

//--- verilog/field_select_stage.sv
/*
  First pipeline register of the decoder. Latches the window, EIP and the
  prefix scan, then picks opcode, ModR/M and SIB behind the prefix run.
  Only valid is reset; the payload is don't-care while valid is low.
*/
`default_nettype none
`timescale 1ns/10ps
`include "x86_decode_config.svh"

module field_select_stage
  import x86_decode_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       fetch_valid,
  input  logic [8*`WINDOW_BYTES-1:0] fetch_bytes,
  input  logic [`EIP_W-1:0]          fetch_eip,
  input  prefix_info_t               pinfo,
  decode_if.stage                    dec
);

  logic                       valid_q;
  logic [8*`WINDOW_BYTES-1:0] bytes_q;
  logic [`EIP_W-1:0]          eip_q;
  prefix_info_t               pinfo_q;
  logic [6:0]                 op_shift;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= fetch_valid;
    end
  end

  always_ff @(posedge clk) begin
    bytes_q <= fetch_bytes;
    eip_q   <= fetch_eip;
    pinfo_q <= pinfo;
  end

  // Opcode sits right after the prefixes
  assign op_shift = {1'b0, pinfo_q.count, 3'b000};

  assign dec.valid  = valid_q;
  assign dec.bytes  = bytes_q;
  assign dec.eip    = eip_q;
  assign dec.pinfo  = pinfo_q;
  assign dec.opcode = 8'(bytes_q >> op_shift);
  assign dec.modrm  = 8'(bytes_q >> (op_shift + 7'd8));
  assign dec.sib    = 8'(bytes_q >> (op_shift + 7'd16));

endmodule

`default_nettype wire

//--- verilog/length_decoder.sv
/*
  Second pipeline register. Classifies the opcode from a fixed table,
  sizes the ModR/M tail and pulls out disp, imm and far-pointer selector.
  Opcodes outside the table decode as one byte and flag de_unsupported.
*/
`default_nettype none
`timescale 1ns/10ps
`include "x86_decode_config.svh"

module length_decoder
  import x86_decode_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  decode_if.decoder         dec,
  output logic              de_valid,
  output logic [`LEN_W-1:0] de_length,
  output logic [`EIP_W-1:0] de_eip_next,
  output logic [7:0]        de_opcode,
  output logic [7:0]        de_modrm,
  output logic [31:0]       de_disp32,
  output logic [31:0]       de_imm32,
  output logic [15:0]       de_ptr_cs,
  output logic              de_repne,
  output logic              de_op_size_over,
  output logic              de_seg_over,
  output seg_e              de_seg,
  output logic              de_esc_0f,
  output logic              de_hlt,
  output logic              de_iret,
  output logic              de_unsupported
);

  op_class_e         op_class;
  logic              has_modrm;
  logic              sib_pr;
  logic [1:0]        mod;
  logic [2:0]        rm;
  logic [`LEN_W-1:0] cnt;
  logic [`LEN_W-1:0] immz_bytes;
  logic [`LEN_W-1:0] imm_bytes;
  logic [`LEN_W-1:0] sel_bytes;
  logic [`LEN_W-1:0] disp_bytes;
  logic [`LEN_W-1:0] tail;
  logic [`LEN_W-1:0] disp_pos;
  logic [`LEN_W-1:0] imm_pos;
  logic [`LEN_W-1:0] ptr_pos;
  logic [`LEN_W-1:0] len;
  logic [31:0]       disp_raw;
  logic [31:0]       imm_raw;
  logic [31:0]       disp;
  logic [31:0]       imm;
  logic [15:0]       ptr_cs;

  always_comb begin
    op_class = OPC_UNSUPPORTED;
    if (dec.pinfo.esc_0f) begin
      if (dec.opcode == 8'h6F || dec.opcode == 8'h7F) begin
        op_class = OPC_MODRM;
      end
    end else begin
      case (dec.opcode) inside
        8'h90, 8'hC3, 8'hF4, 8'hCF: op_class = OPC_NONE;
        8'h01, 8'h03, 8'h89, 8'h8B: op_class = OPC_MODRM;
        8'h83:                      op_class = OPC_MODRM_IMM8;
        8'h81, 8'hC7:               op_class = OPC_MODRM_IMMZ;
        8'h04, 8'h6A:               op_class = OPC_IMM8;
        [8'hB8:8'hBF], 8'hE8, 8'hE9: op_class = OPC_IMMZ;
        8'hEA:                      op_class = OPC_FAR_PTR;
        default:                    op_class = OPC_UNSUPPORTED;
      endcase
    end
  end

  // 66 shrinks a full immediate to 16 bits
  assign immz_bytes = dec.pinfo.op_size ? 4'd2 : 4'd4;

  always_comb begin
    has_modrm = 1'b0;
    imm_bytes = '0;
    sel_bytes = '0;
    case (op_class)
      OPC_MODRM: begin
        has_modrm = 1'b1;
      end
      OPC_MODRM_IMM8: begin
        has_modrm = 1'b1;
        imm_bytes = 4'd1;
      end
      OPC_MODRM_IMMZ: begin
        has_modrm = 1'b1;
        imm_bytes = immz_bytes;
      end
      OPC_IMM8: imm_bytes = 4'd1;
      OPC_IMMZ: imm_bytes = immz_bytes;
      OPC_FAR_PTR: begin
        imm_bytes = immz_bytes;
        sel_bytes = 4'd2;
      end
      default: ;
    endcase
  end

  assign mod = dec.modrm[7:6];
  assign rm  = dec.modrm[2:0];

  // 32-bit addressing forms
  always_comb begin
    sib_pr     = 1'b0;
    disp_bytes = '0;
    if (!has_modrm || mod == 2'b11) begin
      disp_bytes = '0;
    end else if (mod == 2'b00 && rm == 3'b101) begin
      disp_bytes = 4'd4;
    end else begin
      sib_pr = (rm == 3'b100);
      if (mod == 2'b10 || (mod == 2'b00 && sib_pr && dec.sib[2:0] == 3'b101)) begin
        disp_bytes = 4'd4;
      end else if (mod == 2'b01) begin
        disp_bytes = 4'd1;
      end
    end
  end

  assign cnt      = {1'b0, dec.pinfo.count};
  assign tail     = has_modrm ? (4'd1 + {3'b000, sib_pr} + disp_bytes) : '0;
  assign disp_pos = cnt + 4'd2 + {3'b000, sib_pr};
  assign imm_pos  = cnt + 4'd1 + tail;
  assign ptr_pos  = imm_pos + imm_bytes;
  assign len      = ptr_pos + sel_bytes;

  assign disp_raw = 32'(dec.bytes >> {disp_pos, 3'b000});
  assign imm_raw  = 32'(dec.bytes >> {imm_pos, 3'b000});

  always_comb begin
    case (disp_bytes)
      4'd1:    disp = {{24{disp_raw[7]}}, disp_raw[7:0]};
      4'd4:    disp = disp_raw;
      default: disp = '0;
    endcase
    case (imm_bytes)
      4'd1:    imm = {24'h0, imm_raw[7:0]};
      4'd2:    imm = {16'h0, imm_raw[15:0]};
      4'd4:    imm = imm_raw;
      default: imm = '0;
    endcase
  end

  // Selector follows the offset of a far pointer
  assign ptr_cs = (sel_bytes != '0) ? 16'(dec.bytes >> {ptr_pos, 3'b000}) : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      de_valid <= 1'b0;
    end else begin
      de_valid <= dec.valid;
    end
  end

  always_ff @(posedge clk) begin
    de_length       <= len;
    de_eip_next     <= dec.eip + `EIP_W'(len);
    de_opcode       <= dec.opcode;
    de_modrm        <= dec.modrm;
    de_disp32       <= disp;
    de_imm32        <= imm;
    de_ptr_cs       <= ptr_cs;
    de_repne        <= dec.pinfo.repne;
    de_op_size_over <= dec.pinfo.op_size;
    de_seg_over     <= dec.pinfo.seg_over;
    de_seg          <= dec.pinfo.seg;
    de_esc_0f       <= dec.pinfo.esc_0f;
    de_hlt          <= (dec.opcode == 8'hF4);
    de_iret         <= (dec.opcode == 8'hCF);
    de_unsupported  <= (op_class == OPC_UNSUPPORTED);
  end

endmodule

`default_nettype wire

//--- verilog/prefix_scanner.sv
/*
  Combinational prefix scan over the first MAX_PREFIX window bytes.
  Only the leading run of prefixes counts; 0F is treated as a prefix.
  With several segment overrides the order ES, CS, SS, DS, FS, GS decides.
*/
`default_nettype none
`timescale 1ns/10ps
`include "x86_decode_config.svh"

module prefix_scanner
  import x86_decode_pkg::*;
(
  input  logic [8*`MAX_PREFIX-1:0] bytes,
  output prefix_info_t             pinfo
);

  logic [`MAX_PREFIX-1:0] m_repne;
  logic [`MAX_PREFIX-1:0] m_size;
  logic [`MAX_PREFIX-1:0] m_0f;
  logic [`MAX_PREFIX-1:0] m_es;
  logic [`MAX_PREFIX-1:0] m_cs;
  logic [`MAX_PREFIX-1:0] m_ss;
  logic [`MAX_PREFIX-1:0] m_ds;
  logic [`MAX_PREFIX-1:0] m_fs;
  logic [`MAX_PREFIX-1:0] m_gs;
  logic [`MAX_PREFIX-1:0] is_pfx;
  logic [`MAX_PREFIX-1:0] therm;

  for (genvar i = 0; i < `MAX_PREFIX; i++) begin : g_cmp
    logic [7:0] b;
    assign b          = bytes[8*i +: 8];
    assign m_repne[i] = (b == 8'hF2);
    assign m_cs[i]    = (b == 8'h2E);
    assign m_ss[i]    = (b == 8'h36);
    assign m_ds[i]    = (b == 8'h3E);
    assign m_es[i]    = (b == 8'h26);
    assign m_fs[i]    = (b == 8'h64);
    assign m_gs[i]    = (b == 8'h65);
    assign m_size[i]  = (b == 8'h66);
    assign m_0f[i]    = (b == 8'h0F);
    assign is_pfx[i]  = m_repne[i] | m_cs[i] | m_ss[i] | m_ds[i] | m_es[i] |
                        m_fs[i] | m_gs[i] | m_size[i] | m_0f[i];
  end

  // Thermometer mask and run length
  always_comb begin
    logic       run;
    logic [2:0] cnt;
    run = 1'b1;
    cnt = '0;
    for (int i = 0; i < `MAX_PREFIX; i++) begin
      run      = run & is_pfx[i];
      therm[i] = run;
      cnt      = cnt + {2'b00, run};
    end
    pinfo.count = cnt;
  end

  always_comb begin
    pinfo.repne    = |(m_repne & therm);
    pinfo.op_size  = |(m_size & therm);
    pinfo.esc_0f   = |(m_0f & therm);
    pinfo.seg_over = |((m_es | m_cs | m_ss | m_ds | m_fs | m_gs) & therm);
    if (|(m_es & therm)) begin
      pinfo.seg = SEG_ES;
    end else if (|(m_cs & therm)) begin
      pinfo.seg = SEG_CS;
    end else if (|(m_ss & therm)) begin
      pinfo.seg = SEG_SS;
    end else if (|(m_ds & therm)) begin
      pinfo.seg = SEG_DS;
    end else if (|(m_fs & therm)) begin
      pinfo.seg = SEG_FS;
    end else if (|(m_gs & therm)) begin
      pinfo.seg = SEG_GS;
    end else begin
      // Default data segment
      pinfo.seg = SEG_DS;
    end
  end

endmodule

`default_nettype wire

//--- verilog/x86_decode_config.svh
/*
  Sizing for the x86 decode stage. The prefix scan covers the first
  MAX_PREFIX bytes only, and an instruction must fit inside one window.
*/
`ifndef X86_DECODE_CONFIG_SVH
`define X86_DECODE_CONFIG_SVH

// Fetch window in bytes
`define WINDOW_BYTES 16

// Leading positions checked for prefix bytes
`define MAX_PREFIX 4

// Instruction pointer width
`define EIP_W 32

// Instruction length field, lengths up to 15 bytes
`define LEN_W 4

`endif

//--- verilog/x86_decode_pkg.sv
/*
  Shared types for the decode stage. The opcode classes cover a fixed
  subset of IA-32 and carry length information only.
*/
`default_nettype none

package x86_decode_pkg;

  typedef enum logic [2:0] {
    SEG_ES = 3'd0,
    SEG_CS = 3'd1,
    SEG_SS = 3'd2,
    SEG_DS = 3'd3,
    SEG_FS = 3'd4,
    SEG_GS = 3'd5
  } seg_e;

  typedef enum logic [2:0] {
    OPC_NONE        = 3'd0,
    OPC_MODRM       = 3'd1,
    OPC_MODRM_IMM8  = 3'd2,
    OPC_MODRM_IMMZ  = 3'd3,
    OPC_IMM8        = 3'd4,
    OPC_IMMZ        = 3'd5,
    OPC_FAR_PTR     = 3'd6,
    OPC_UNSUPPORTED = 3'd7
  } op_class_e;

  // Result of the leading prefix scan
  typedef struct packed {
    logic [2:0] count;
    logic       repne;
    logic       op_size;
    logic       esc_0f;
    logic       seg_over;
    seg_e       seg;
  } prefix_info_t;

endpackage

`default_nettype wire

//--- verilog/x86_decode_top.sv
/*
  x86 decode stage top level. Results appear two cycles after fetch_valid,
  one instruction per strobe, with no back-pressure.
  de_* data outputs are don't-care while de_valid is low.
*/
`default_nettype none
`timescale 1ns/10ps
`include "x86_decode_config.svh"

module x86_decode_top
  import x86_decode_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       fetch_valid,
  input  logic [8*`WINDOW_BYTES-1:0] fetch_bytes,
  input  logic [`EIP_W-1:0]          fetch_eip,
  output logic                       de_valid,
  output logic [`LEN_W-1:0]          de_length,
  output logic [`EIP_W-1:0]          de_eip_next,
  output logic [7:0]                 de_opcode,
  output logic [7:0]                 de_modrm,
  output logic [31:0]                de_disp32,
  output logic [31:0]                de_imm32,
  output logic [15:0]                de_ptr_cs,
  output logic                       de_repne,
  output logic                       de_op_size_over,
  output logic                       de_seg_over,
  output seg_e                       de_seg,
  output logic                       de_esc_0f,
  output logic                       de_hlt,
  output logic                       de_iret,
  output logic                       de_unsupported
);

  prefix_info_t pinfo;

  decode_if dec_bus ();

  prefix_scanner u_scan (
    .bytes (fetch_bytes[8*`MAX_PREFIX-1:0]),
    .pinfo (pinfo)
  );

  field_select_stage u_fields (
    .clk         (clk),
    .rst         (rst),
    .fetch_valid (fetch_valid),
    .fetch_bytes (fetch_bytes),
    .fetch_eip   (fetch_eip),
    .pinfo       (pinfo),
    .dec         (dec_bus.stage)
  );

  length_decoder u_len (
    .clk             (clk),
    .rst             (rst),
    .dec             (dec_bus.decoder),
    .de_valid        (de_valid),
    .de_length       (de_length),
    .de_eip_next     (de_eip_next),
    .de_opcode       (de_opcode),
    .de_modrm        (de_modrm),
    .de_disp32       (de_disp32),
    .de_imm32        (de_imm32),
    .de_ptr_cs       (de_ptr_cs),
    .de_repne        (de_repne),
    .de_op_size_over (de_op_size_over),
    .de_seg_over     (de_seg_over),
    .de_seg          (de_seg),
    .de_esc_0f       (de_esc_0f),
    .de_hlt          (de_hlt),
    .de_iret         (de_iret),
    .de_unsupported  (de_unsupported)
  );

endmodule

`default_nettype wire

//--- x86_decode.f
+incdir+verilog
verilog/x86_decode_pkg.sv
verilog/decode_if.sv
verilog/prefix_scanner.sv
verilog/field_select_stage.sv
verilog/length_decoder.sv
verilog/x86_decode_top.sv
tests/tb_clock.sv
tests/x86_decode_tb.sv
